/* src/rvPkg.sv */
package rvPkg;

    // Major opcode, instruction bits [6:2]
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        STORE  = 5'b01000,
        OP_IMM = 5'b00100,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100
    } OpCode;

    typedef logic [4:0] RegAddr;

    // funct3 of OP and OP_IMM
    typedef enum logic [2:0] {
        FnAddSub = 3'b000,
        FnSll    = 3'b001,
        FnSlt    = 3'b010,
        FnSltu   = 3'b011,
        FnXor    = 3'b100,
        FnSrlSra = 3'b101, // funct7[5] picks arithmetic
        FnOr     = 3'b110,
        FnAnd    = 3'b111
    } AluFunct;

    typedef enum logic [2:0] {
        Beq  = 3'b000,
        Bne  = 3'b001,
        Blt  = 3'b100,
        Bge  = 3'b101,
        Bltu = 3'b110,
        Bgeu = 3'b111
    } BranchFunct;

    // Load/store width, funct3[1:0]
    typedef enum logic [1:0] {
        Bits8    = 2'b00,
        Bits16   = 2'b01,
        Bits32   = 2'b10,
        WidthErr = 2'b11
    } MemWidth;

    typedef enum logic [3:0] {
        Add,
        Sub,
        Sll,
        Slt,
        Sltu,
        Xor,
        Srl,
        Sra,
        Or,
        And
    } AluOp;

    typedef enum logic {
        WbAlu,
        WbLink
    } WbSel;

    typedef struct packed {
        logic [6:0] funct7;
        RegAddr     rs2;
        RegAddr     rs1;
        logic [2:0] funct3;
        RegAddr     rd;
        OpCode      opCode;
        logic [1:0] low; // Always 2'b11 in RV32I
    } RType;

    typedef struct packed {
        logic [11:0] imm11_0;
        RegAddr      rs1;
        logic [2:0]  funct3;
        RegAddr      rd;
        OpCode       opCode;
        logic [1:0]  low;
    } IType;

    typedef struct packed {
        logic [6:0] immHi;
        RegAddr     rs2;
        RegAddr     rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        OpCode      opCode;
        logic [1:0] low;
    } SType;

    typedef struct packed {
        logic [19:0] imm31_12;
        RegAddr      rd;
        OpCode       opCode;
        logic [1:0]  low;
    } UType;

    // B and J immediates are scattered over the S and U views
    typedef union packed {
        RType rType;
        IType iType;
        SType sType;
        UType uType;
    } Instruction;

endpackage

/* src/decodedIf.sv */
`timescale 1ns/1ps

interface decodedIf;
    import rvPkg::*;

    AluOp        aluOp;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] imm;          // Immediate of the current format
    RegAddr      rd;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic [31:0] pc;
    logic        rdWrite;      // Not yet gated by illegal
    logic        isBranch;
    logic        isJal;
    logic        isJalr;
    logic        memRead;
    logic        memWrite;
    logic        memSigned;
    logic        illegal;
    BranchFunct  branchFunct;
    MemWidth     memWidth;

    modport decoder(output aluOp, opA, opB, imm, rd, rs1Val, rs2Val, pc, rdWrite, isBranch,
                    isJal, isJalr, memRead, memWrite, memSigned, illegal, branchFunct, memWidth);
    modport alu(input aluOp, opA, opB, imm, rd, rs1Val, rs2Val, pc, rdWrite, isBranch,
                isJal, isJalr, memRead, memWrite, memSigned, illegal, branchFunct, memWidth);
    modport merge(input aluOp, opA, opB, imm, rd, rs1Val, rs2Val, pc, rdWrite, isBranch,
                  isJal, isJalr, memRead, memWrite, memSigned, illegal, branchFunct, memWidth);

endinterface

/* src/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    decodedIf.decoder       dec,
    input rvPkg::Instruction instr,
    input logic [31:0]      pc,
    input logic [31:0]      rs1Val,
    input logic [31:0]      rs2Val
);
    import rvPkg::*;

    OpCode       opCode;
    AluFunct     aluFunct;
    AluOp        aluOpSel;
    logic        altFunct;
    logic        widthErr;
    logic        writesRd;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    assign opCode   = instr.rType.opCode;
    assign aluFunct = AluFunct'(instr.rType.funct3);
    assign altFunct = instr.rType.funct7[5];       // SUB / SRA select
    assign widthErr = (instr.rType.funct3[1:0] == 2'b11);

    assign immI = {{20{instr.iType.imm11_0[11]}}, instr.iType.imm11_0};
    assign immS = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
    assign immB = {{20{instr.sType.immHi[6]}}, instr.sType.immLo[0], instr.sType.immHi[5:0],
                   instr.sType.immLo[4:1], 1'b0};
    assign immU = {instr.uType.imm31_12, 12'h000};
    assign immJ = {{12{instr.uType.imm31_12[19]}}, instr.uType.imm31_12[7:0],
                   instr.uType.imm31_12[8], instr.uType.imm31_12[18:9], 1'b0};

    // funct3/funct7 to ALU operation
    always_comb begin
        case (aluFunct)
            FnAddSub: aluOpSel = (opCode == OP && altFunct) ? Sub : Add; // No SUBI
            FnSll:    aluOpSel = Sll;
            FnSlt:    aluOpSel = Slt;
            FnSltu:   aluOpSel = Sltu;
            FnXor:    aluOpSel = Xor;
            FnSrlSra: aluOpSel = altFunct ? Sra : Srl;
            FnOr:     aluOpSel = Or;
            default:  aluOpSel = And;
        endcase
    end

    always_comb begin
        dec.imm       = immI;
        dec.opA       = rs1Val;
        dec.opB       = immI;
        dec.aluOp     = Add;      // Address and target sums
        writesRd      = 1'b0;
        dec.isBranch  = 1'b0;
        dec.isJal     = 1'b0;
        dec.isJalr    = 1'b0;
        dec.memRead   = 1'b0;
        dec.memWrite  = 1'b0;
        dec.memSigned = 1'b0;
        dec.illegal   = 1'b0;
        case (opCode)
            LOAD: begin
                writesRd      = 1'b1;
                dec.memRead   = 1'b1;
                dec.memSigned = ~instr.rType.funct3[2];
                dec.illegal   = widthErr;
            end
            STORE: begin
                dec.imm      = immS;
                dec.opB      = immS;
                dec.memWrite = 1'b1;
                dec.illegal  = instr.sType.funct3[2] | widthErr;
            end
            OP_IMM: begin
                writesRd  = 1'b1;
                dec.aluOp = aluOpSel;
            end
            OP: begin
                writesRd  = 1'b1;
                dec.opB   = rs2Val;
                dec.aluOp = aluOpSel;
            end
            LUI: begin
                writesRd = 1'b1;
                dec.imm  = immU;
                dec.opA  = 32'h0;
                dec.opB  = immU;
            end
            AUIPC: begin
                writesRd = 1'b1;
                dec.imm  = immU;
                dec.opA  = pc;
                dec.opB  = immU;
            end
            BRANCH: begin
                dec.imm      = immB;
                dec.opB      = rs2Val;
                dec.isBranch = 1'b1;
            end
            JAL: begin
                writesRd  = 1'b1;
                dec.imm   = immJ;
                dec.opB   = immJ;
                dec.isJal = 1'b1;
            end
            JALR: begin
                writesRd   = 1'b1;
                dec.isJalr = 1'b1;
            end
            default: dec.illegal = 1'b1; // SYSTEM and unknown opcodes
        endcase
        dec.rdWrite = writesRd && (instr.rType.rd != 5'd0); // x0 is never written
    end

    assign dec.rd          = instr.rType.rd;
    assign dec.rs1Val      = rs1Val;
    assign dec.rs2Val      = rs2Val;
    assign dec.pc          = pc;
    assign dec.branchFunct = BranchFunct'(instr.rType.funct3);
    assign dec.memWidth    = MemWidth'(instr.rType.funct3[1:0]);

endmodule

/* src/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    decodedIf.alu       dec,
    output logic [31:0] aluResult
);
    import rvPkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = dec.opB[4:0]; // Only the low 5 bits count
    assign ltSigned   = $signed(dec.opA) < $signed(dec.opB);
    assign ltUnsigned = dec.opA < dec.opB;

    always_comb begin
        case (dec.aluOp)
            Add: begin
                aluResult = dec.opA + dec.opB;
            end
            Sub: begin
                aluResult = dec.opA - dec.opB;
            end
            Sll: begin
                aluResult = dec.opA << shamt;
            end
            Slt: begin
                aluResult = {31'h0, ltSigned};
            end
            Sltu: begin
                aluResult = {31'h0, ltUnsigned};
            end
            Xor: begin
                aluResult = dec.opA ^ dec.opB;
            end
            Srl: begin
                aluResult = dec.opA >> shamt;
            end
            Sra: begin
                aluResult = $signed(dec.opA) >>> shamt; // Sign bit fills the top
            end
            Or: begin
                aluResult = dec.opA | dec.opB;
            end
            And: begin
                aluResult = dec.opA & dec.opB;
            end
            default: begin
                aluResult = dec.opA + dec.opB; // Unused encodings
            end
        endcase
    end

endmodule

/* src/branchUnit.sv */
`timescale 1ns/1ps

module branchUnit (
    decodedIf.alu       dec,
    output logic [31:0] nextPc,
    output logic [31:0] linkVal
);
    import rvPkg::*;

    logic        isEq;
    logic        isLt;
    logic        isLtu;
    logic        cmpRaw;
    logic        codeOk;
    logic        taken;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic [31:0] regTarget;

    // Compare runs beside the ALU, not through it
    assign isEq  = dec.rs1Val == dec.rs2Val;
    assign isLt  = $signed(dec.rs1Val) < $signed(dec.rs2Val);
    assign isLtu = dec.rs1Val < dec.rs2Val;

    always_comb begin
        case (dec.branchFunct)
            Beq, Bne:   cmpRaw = isEq;
            Blt, Bge:   cmpRaw = isLt;
            Bltu, Bgeu: cmpRaw = isLtu;
            default:    cmpRaw = 1'b0;
        endcase
    end

    assign codeOk = dec.branchFunct[2:1] != 2'b01;  // funct3 010/011 never taken
    assign taken  = dec.isBranch && codeOk && (cmpRaw ^ dec.branchFunct[0]); // Odd codes invert

    assign pcPlus4   = dec.pc + 32'd4;
    assign pcTarget  = dec.pc + dec.imm;                        // B or J immediate
    assign regTarget = (dec.rs1Val + dec.imm) & 32'hffff_fffe;  // JALR clears bit 0

    always_comb begin
        if (dec.isJalr) begin
            nextPc = regTarget;
        end else if (taken || dec.isJal) begin
            nextPc = pcTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    assign linkVal = pcPlus4;

endmodule

/* src/resultMerge.sv */
`timescale 1ns/1ps

module resultMerge (
    input  logic          clk,
    input  logic          rst,
    decodedIf.merge       dec,
    input  logic [31:0]   aluResult,
    input  logic [31:0]   nextPcIn,
    input  logic [31:0]   linkVal,
    input  logic          inValid,
    output logic          inReady,
    output logic          outValid,
    input  logic          outReady,
    output logic          rdWrite,
    output rvPkg::RegAddr rdAddr,
    output logic [31:0]   rdValue,
    output logic [31:0]   nextPc,
    output logic          memRead,
    output logic          memWrite,
    output logic [31:0]   memAddr,
    output rvPkg::MemWidth memWidth,
    output logic          memSigned,
    output logic          illegal
);
    import rvPkg::*;

    WbSel        wbSel;
    logic [31:0] wbValue;
    logic        accept;

    // Empty or draining this cycle
    assign inReady = !outValid || outReady;
    assign accept  = inValid && inReady;

    always_comb begin
        wbSel = (dec.isJal || dec.isJalr) ? WbLink : WbAlu;
        case (wbSel)
            WbLink:  wbValue = linkVal;
            default: wbValue = aluResult; // Includes the LOAD address sum
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (accept) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    // Result word only loads on a transfer, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            rdWrite   <= dec.rdWrite && !dec.illegal;
            rdAddr    <= dec.rd;
            rdValue   <= wbValue;
            nextPc    <= nextPcIn;
            memRead   <= dec.memRead && !dec.illegal;
            memWrite  <= dec.memWrite && !dec.illegal;
            memAddr   <= aluResult;
            memWidth  <= dec.memWidth;
            memSigned <= dec.memSigned && !dec.illegal;
            illegal   <= dec.illegal;
        end
    end

endmodule

/* src/execStage.sv */
`timescale 1ns/1ps

module execStage (
    input  logic           clk,
    input  logic           rst,
    input  logic           inValid,
    output logic           inReady,
    input  logic [31:0]    instr,
    input  logic [31:0]    pc,
    input  logic [31:0]    rs1Val,
    input  logic [31:0]    rs2Val,
    output logic           outValid,
    input  logic           outReady,
    output logic           rdWrite,
    output rvPkg::RegAddr  rdAddr,
    output logic [31:0]    rdValue,
    output logic [31:0]    nextPc,
    output logic           memRead,
    output logic           memWrite,
    output logic [31:0]    memAddr,
    output rvPkg::MemWidth memWidth,
    output logic           memSigned,
    output logic           illegal
);

    logic [31:0] aluResult;
    logic [31:0] branchNextPc;
    logic [31:0] linkVal;

    decodedIf decBus ();

    instrDecoder uDecoder (
        .dec    (decBus),
        .instr  (instr),
        .pc     (pc),
        .rs1Val (rs1Val),
        .rs2Val (rs2Val)
    );

    aluUnit uAlu (
        .dec       (decBus),
        .aluResult (aluResult)
    );

    branchUnit uBranch (
        .dec     (decBus),
        .nextPc  (branchNextPc),
        .linkVal (linkVal)
    );

    resultMerge uMerge (
        .clk       (clk),
        .rst       (rst),
        .dec       (decBus),
        .aluResult (aluResult),
        .nextPcIn  (branchNextPc),
        .linkVal   (linkVal),
        .inValid   (inValid),
        .inReady   (inReady),
        .outValid  (outValid),
        .outReady  (outReady),
        .rdWrite   (rdWrite),
        .rdAddr    (rdAddr),
        .rdValue   (rdValue),
        .nextPc    (nextPc),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .memAddr   (memAddr),
        .memWidth  (memWidth),
        .memSigned (memSigned),
        .illegal   (illegal)
    );

endmodule

/* tb/execStage_props.sv */
`timescale 1ns/1ps

module execStageProps (
    input logic        clk,
    input logic        rst,
    input logic        outValid,
    input logic        outReady,
    input logic        rdWrite,
    input logic [4:0]  rdAddr,
    input logic [31:0] rdValue,
    input logic [31:0] nextPc,
    input logic        memRead,
    input logic        memWrite,
    input logic [31:0] memAddr,
    input logic [1:0]  memWidth,
    input logic        memSigned,
    input logic        illegal
);

    logic [107:0] resultWord;

    assign resultWord = {rdWrite, rdAddr, rdValue, nextPc, memRead, memWrite, memAddr,
                         memWidth, memSigned, illegal};

    // Held result must not move until the consumer takes it
    holdUnderStall: assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(resultWord))
        else $error("result changed or was dropped while outReady was low");

    illegalIsQuiet: assert property (@(posedge clk) disable iff (rst)
        outValid && illegal |-> !rdWrite && !memRead && !memWrite)
        else $error("illegal instruction still writes or requests memory");

    emptyAfterReset: assert property (@(posedge clk) rst |=> !outValid)
        else $error("outValid is high in the cycle after reset");

endmodule

bind resultMerge execStageProps uProps (
    .clk       (clk),
    .rst       (rst),
    .outValid  (outValid),
    .outReady  (outReady),
    .rdWrite   (rdWrite),
    .rdAddr    (rdAddr),
    .rdValue   (rdValue),
    .nextPc    (nextPc),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .memAddr   (memAddr),
    .memWidth  (memWidth),
    .memSigned (memSigned),
    .illegal   (illegal)
);

/* tb/execStageTb.sv */
`timescale 1ns/1ps

module execStageTb;
    import rvPkg::*;

    localparam int NumTxn   = 600;
    localparam int MaxCycle = NumTxn * 8 + 50;

    typedef struct packed {
        logic        rdWrite;
        logic [4:0]  rdAddr;
        logic [31:0] rdValue;
        logic [31:0] nextPc;
        logic        memRead;
        logic        memWrite;
        logic [31:0] memAddr;
        logic [1:0]  memWidth;
        logic        memSigned;
        logic        illegal;
    } Expected;

    logic        clk;
    logic        rst;
    logic        inValid;
    logic        inReady;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1Val;
    logic [31:0] rs2Val;
    logic        outValid;
    logic        outReady;
    logic        rdWrite;
    RegAddr      rdAddr;
    logic [31:0] rdValue;
    logic [31:0] nextPc;
    logic        memRead;
    logic        memWrite;
    logic [31:0] memAddr;
    MemWidth     memWidth;
    logic        memSigned;
    logic        illegal;

    Expected     expQ[$];       // Model results in acceptance order
    logic [31:0] rngState;
    int          cycleCount = 0;

    execStage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > MaxCycle) begin
            $display("timeout: the run did not finish within %0d cycles", MaxCycle);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic sub,
                                             input logic arith, input logic [31:0] x,
                                             input logic [31:0] y);
        logic [31:0] r;
        case (f3)
            3'd0: r = sub ? x - y : x + y;
            3'd1: r = x << y[4:0];
            3'd2: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3: r = (x < y) ? 32'd1 : 32'd0;
            3'd4: r = x ^ y;
            3'd5: begin
                if (arith) begin
                    r = $signed(x) >>> y[4:0];
                end else begin
                    r = x >> y[4:0];
                end
            end
            3'd6: r = x | y;
            default: r = x & y;
        endcase
        return r;
    endfunction

    function automatic Expected modelResult(input logic [31:0] ins, input logic [31:0] pcIn,
                                            input logic [31:0] a, input logic [31:0] b);
        Expected     e;
        logic [2:0]  f3;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic        writes;
        logic        taken;
        f3   = ins[14:12];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'h000};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        e          = '0;
        e.rdAddr   = ins[11:7];
        e.nextPc   = pcIn + 32'd4;
        e.memWidth = f3[1:0];
        writes     = 1'b0;
        taken      = 1'b0;
        case (ins[6:2])
            OP: begin
                writes    = 1'b1;
                e.rdValue = aluModel(f3, ins[30], ins[30], a, b);
            end
            OP_IMM: begin
                writes    = 1'b1;
                e.rdValue = aluModel(f3, 1'b0, ins[30], a, immI); // No SUBI
            end
            LUI: begin
                writes    = 1'b1;
                e.rdValue = immU;
            end
            AUIPC: begin
                writes    = 1'b1;
                e.rdValue = pcIn + immU;
            end
            JAL: begin
                writes    = 1'b1;
                e.rdValue = pcIn + 32'd4;
                e.nextPc  = pcIn + immJ;
            end
            JALR: begin
                writes    = 1'b1;
                e.rdValue = pcIn + 32'd4;
                e.nextPc  = (a + immI) & 32'hffff_fffe;
            end
            BRANCH: begin
                case (f3)
                    3'b000: taken = a == b;
                    3'b001: taken = a != b;
                    3'b100: taken = $signed(a) < $signed(b);
                    3'b101: taken = $signed(a) >= $signed(b);
                    3'b110: taken = a < b;
                    3'b111: taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    e.nextPc = pcIn + immB;
                end
            end
            LOAD: begin
                writes      = 1'b1;
                e.memRead   = 1'b1;
                e.memSigned = !f3[2];
                e.memAddr   = a + immI;
                e.rdValue   = e.memAddr;  // Loaded data arrives after this stage
                e.illegal   = f3[1:0] == 2'b11;
            end
            STORE: begin
                e.memWrite = 1'b1;
                e.memAddr  = a + immS;
                e.illegal  = f3[2] || (f3[1:0] == 2'b11);
            end
            default: e.illegal = 1'b1;
        endcase
        e.rdWrite   = writes && (e.rdAddr != 5'd0) && !e.illegal;
        e.memRead   = e.memRead && !e.illegal;
        e.memWrite  = e.memWrite && !e.illegal;
        e.memSigned = e.memSigned && !e.illegal;
        return e;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1);
        end
    endtask

    task automatic compareResult(input Expected e);
        checkValue("illegal", 32'(illegal), 32'(e.illegal));
        checkValue("rdWrite", 32'(rdWrite), 32'(e.rdWrite));
        checkValue("memRead", 32'(memRead), 32'(e.memRead));
        checkValue("memWrite", 32'(memWrite), 32'(e.memWrite));
        checkValue("memSigned", 32'(memSigned), 32'(e.memSigned));
        checkValue("nextPc", nextPc, e.nextPc);
        if (e.rdWrite) begin
            checkValue("rdAddr", 32'(rdAddr), 32'(e.rdAddr));
            checkValue("rdValue", rdValue, e.rdValue);
        end
        if (e.memRead || e.memWrite) begin
            checkValue("memAddr", memAddr, e.memAddr);
            checkValue("memWidth", 32'(memWidth), 32'(e.memWidth));
        end
    endtask

    // Weighted opcode mix with random fields, pc and operands
    task automatic makeInstruction();
        logic [31:0] word;
        logic [4:0]  opc;
        rngState = xorshift32(rngState);
        word     = rngState;
        rngState = xorshift32(rngState);
        case (rngState[3:0])
            4'd0, 4'd1, 4'd2: opc = OP;
            4'd3, 4'd4, 4'd5: opc = OP_IMM;
            4'd6:    opc = LUI;
            4'd7:    opc = AUIPC;
            4'd8, 4'd9: opc = BRANCH;
            4'd10:   opc = JAL;
            4'd11:   opc = JALR;
            4'd12:   opc = LOAD;
            4'd13:   opc = STORE;
            4'd14:   opc = SYSTEM;
            default: opc = rngState[8:4]; // Mostly unknown codes
        endcase
        if (opc == BRANCH && word[14:13] == 2'b01) begin
            word[14] = 1'b1;              // Keep to the six real conditions
        end
        if (rngState[11:9] == 3'd0) begin
            word[11:7] = 5'd0;
        end
        word[6:0] = {opc, 2'b11};
        instr     = word;
        rngState  = xorshift32(rngState);
        pc        = {rngState[31:2], 2'b00};
        rngState  = xorshift32(rngState);
        rs1Val    = rngState;
        rngState  = xorshift32(rngState);
        rs2Val    = (rngState[1:0] == 2'b00) ? rs1Val : xorshift32(rngState); // Equal now and then
    endtask

    initial begin : stimulus
        int   sentCount;
        int   outCount;
        logic pending;
        logic modelFull;
        logic accept;
        logic drain;
        sentCount = 0;
        outCount  = 0;
        pending   = 1'b0;
        modelFull = 1'b0;
        rngState  = 32'hab53;
        rst       = 1'b1;
        inValid   = 1'b0;
        instr     = 32'h0;
        pc        = 32'h0;
        rs1Val    = 32'h0;
        rs2Val    = 32'h0;
        outReady  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (outCount < NumTxn) begin
            @(negedge clk);
            checkValue("outValid", 32'(outValid), 32'(modelFull));
            rngState = xorshift32(rngState);
            outReady = rngState[2:0] != 3'd0;   // Stall about one cycle in eight
            if (!pending && sentCount < NumTxn && rngState[6:4] != 3'd0) begin
                makeInstruction();
                pending = 1'b1;
            end
            inValid = pending;
            #1;
            checkValue("inReady", 32'(inReady), 32'(!modelFull || outReady));
            accept = inValid && inReady;
            drain  = outValid && outReady;
            if (drain) begin
                compareResult(expQ.pop_front());
                outCount++;
            end
            if (accept) begin
                expQ.push_back(modelResult(instr, pc, rs1Val, rs2Val));
                sentCount++;
                pending = 1'b0;
            end
            modelFull = accept ? 1'b1 : (drain ? 1'b0 : modelFull);
        end
        @(negedge clk);
        checkValue("outValid", 32'(outValid), 32'h0); // No result after the last one
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* build.f */
src/rvPkg.sv
src/decodedIf.sv
src/instrDecoder.sv
src/aluUnit.sv
src/branchUnit.sv
src/resultMerge.sv
src/execStage.sv
tb/execStage_props.sv
tb/execStageTb.sv

/* Makefile */
TOP = execStageTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f build.f -Mdir obj_dir

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir
